//--- sim.f
verilog/fp_format_pkg.sv
verilog/fp_ctrl_pkg.sv
verilog/fp_step_timer.sv
verilog/fp_bus_slave.sv
verilog/fp_sequencer.sv
verilog/fp_datapath.sv
verilog/fpu_top.sv
tb/fpu_asserts.sv
tb/tb_fpu.sv

//--- Bender.yml
package:
  name: fpu

sources:
  - verilog/fp_format_pkg.sv
  - verilog/fp_ctrl_pkg.sv
  - verilog/fp_step_timer.sv
  - verilog/fp_bus_slave.sv
  - verilog/fp_sequencer.sv
  - verilog/fp_datapath.sv
  - verilog/fpu_top.sv
  - target: simulation
    files:
      - tb/fpu_asserts.sv
      - tb/tb_fpu.sv

//--- tb/tb_fpu.sv
//////////////////////////////
// fpu testbench
// table and random add/subtract cases over wishbone
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_fpu;

	localparam int num_vec = 12;
	localparam int num_rand = 24;
	// three directed runs outside the table
	localparam int max_cycles = 200 * (num_vec + num_rand + 3);

	logic got_fp;
	logic _0_f_;
	logic cyc, stb, we;
	fp_ctrl_pkg::adr_t adr;
	fp_format_pkg::fp_word_t dat_w;
	fp_format_pkg::fp_word_t dat_r;
	logic ack;

	// a, b, op nibble, result, status
	logic [67:0] vec_table [num_vec];
	int cycles;
	integer seed;
	logic [31:0] r;
	logic [15:0] ra, rb, xres, xstat, rd, state_v, idle_v;
	logic rop;

	fpu_top dut (
		.got_fp(got_fp), ._0_f_(_0_f_), .cyc(cyc), .stb(stb), .we(we),
		.adr(adr), .dat_w(dat_w), .dat_r(dat_r), .ack(ack)
	);

	always #4 got_fp = ~got_fp;

	always @(posedge got_fp) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles)
			stop_with_failure($sformatf("timeout after %0d cycles", cycles));
	end

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		if (actual !== expected)
			stop_with_failure($sformatf("error: %s expected %h actual %h",
				name, expected, actual));
	endtask

	// one classic cycle, entered and left on a falling edge
	task automatic bus_access(input string name, input logic write,
		input fp_ctrl_pkg::adr_t addr, input logic [15:0] wdata,
		output logic [15:0] rdata);
		cyc = 1'b1;
		stb = 1'b1;
		we = write;
		adr = addr;
		dat_w = wdata;
		@(negedge got_fp);
		check_value({name, " ack"}, 16'd1, {15'd0, ack});
		rdata = dat_r;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		@(negedge got_fp);
		check_value({name, " single ack"}, 16'd0, {15'd0, ack});
	endtask

	task automatic bus_write(input string name, input fp_ctrl_pkg::adr_t addr,
		input logic [15:0] data);
		logic [15:0] unused;
		bus_access(name, 1'b1, addr, data, unused);
	endtask

	task automatic bus_read(input string name, input fp_ctrl_pkg::adr_t addr,
		output logic [15:0] data);
		bus_access(name, 1'b0, addr, 16'h0000, data);
	endtask

	task automatic wait_until_idle(input string name, output logic [15:0] status);
		bus_read({name, " status"}, fp_ctrl_pkg::addr_ctrl, status);
		check_value({name, " busy bit"}, 16'd1, {15'd0, status[fp_ctrl_pkg::stat_busy]});
		while (status[fp_ctrl_pkg::stat_busy])
			bus_read({name, " poll"}, fp_ctrl_pkg::addr_ctrl, status);
	endtask

	task automatic start_case(input string name, input logic [15:0] a,
		input logic [15:0] b, input logic op);
		logic [15:0] data;
		logic [15:0] ctrl;
		bus_write({name, " wr a"}, fp_ctrl_pkg::addr_a, a);
		bus_write({name, " wr b"}, fp_ctrl_pkg::addr_b, b);
		bus_read({name, " rd a"}, fp_ctrl_pkg::addr_a, data);
		check_value({name, " a readback"}, a, data);
		bus_read({name, " rd b"}, fp_ctrl_pkg::addr_b, data);
		check_value({name, " b readback"}, b, data);
		ctrl = '0;
		ctrl[fp_ctrl_pkg::ctrl_op_bit] = op;
		bus_write({name, " ctrl"}, fp_ctrl_pkg::addr_ctrl, ctrl);
	endtask

	task automatic finish_case(input string name, input logic [15:0] exp_res,
		input logic [15:0] exp_stat);
		logic [15:0] status;
		logic [15:0] data;
		wait_until_idle(name, status);
		check_value({name, " status"}, exp_stat, status);
		bus_read({name, " rd res"}, fp_ctrl_pkg::addr_res, data);
		check_value({name, " result"}, exp_res, data);
	endtask

	task automatic run_case(input string name, input logic [15:0] a,
		input logic [15:0] b, input logic op, input logic [15:0] exp_res,
		input logic [15:0] exp_stat);
		start_case(name, a, b, op);
		finish_case(name, exp_res, exp_stat);
	endtask

	// add rule with truncation, saturating exponent and flush on underflow
	task automatic compute_expected(input logic [15:0] a, input logic [15:0] b,
		input logic op, output logic [15:0] res, output logic [15:0] stat);
		int ea, eb, ma, mb, mag_a, mag_b, e, ml, ms, diff, m;
		logic sa, sb, s, zero, ovf, unf;
		sa = a[15];
		sb = b[15] ^ op;
		ea = a[14:10];
		eb = b[14:10];
		ma = a[9:0];
		mb = b[9:0];
		mag_a = (ma == 0) ? 0 : ea * 1024 + ma;
		mag_b = (mb == 0) ? 0 : eb * 1024 + mb;
		if (mag_b > mag_a) begin
			s = sb;
			e = eb;
			ml = mb;
			ms = ma;
			diff = eb - ea;
		end else begin
			s = sa;
			e = ea;
			ml = ma;
			ms = mb;
			diff = ea - eb;
		end
		ms = (diff < 0 || diff > 10) ? 0 : ms >> diff;
		m = (sa != sb) ? ml - ms : ml + ms;
		zero = 1'b0;
		ovf = 1'b0;
		unf = 1'b0;
		if (m > 1023) begin
			m = m / 2;
			if (e == 31)
				ovf = 1'b1;
			else
				e = e + 1;
		end
		if (m == 0)
			zero = 1'b1;
		while (m != 0 && m < 512 && !unf) begin
			if (e == 0) begin
				unf = 1'b1;
			end else begin
				m = m * 2;
				e = e - 1;
			end
		end
		res = (zero || unf) ? 16'h0000 : {s, e[4:0], m[9:0]};
		stat = '0;
		stat[fp_ctrl_pkg::ctrl_op_bit] = op;
		stat[fp_ctrl_pkg::stat_zero] = zero;
		stat[fp_ctrl_pkg::stat_ovf] = ovf;
		stat[fp_ctrl_pkg::stat_unf] = unf;
	endtask

	task automatic fill_table();
		vec_table[0] = {16'h1600, 16'h0E00, 4'h0, 16'h1680, 16'h0000};
		vec_table[1] = {16'h1300, 16'h1300, 4'h0, 16'h1700, 16'h0000};
		vec_table[2] = {16'h1BFF, 16'h12FF, 4'h0, 16'h1E5F, 16'h0000};
		vec_table[3] = {16'h2A01, 16'h2A00, 4'h1, 16'h0600, 16'h0001};
		vec_table[4] = {16'h2A00, 16'h2A00, 4'h1, 16'h0000, 16'h0003};
		vec_table[5] = {16'h0E00, 16'h1700, 4'h1, 16'h9680, 16'h0001};
		vec_table[6] = {16'h9300, 16'h1200, 4'h0, 16'h8E00, 16'h0000};
		vec_table[7] = {16'h7E00, 16'h7E00, 4'h0, 16'h7E00, 16'h0004};
		vec_table[8] = {16'h0A01, 16'h0A00, 4'h1, 16'h0000, 16'h0009};
		vec_table[9] = {16'h0000, 16'h1600, 4'h0, 16'h1600, 16'h0000};
		vec_table[10] = {16'h53FF, 16'h17FF, 4'h0, 16'h53FF, 16'h0000};
		vec_table[11] = {16'h1300, 16'h9200, 4'h1, 16'h1680, 16'h0001};
	endtask

	initial begin
		got_fp = 1'b0;
		_0_f_ = 1'b0;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		dat_w = '0;
		cycles = 0;
		seed = 14179;
		idle_v = fp_ctrl_pkg::seq_idle;
		fill_table();
		repeat (3) @(negedge got_fp);
		_0_f_ = 1'b1;
		check_value("reset ack", 16'd0, {15'd0, ack});

		for (int i = 0; i < num_vec; i++)
			run_case($sformatf("vec%0d", i), vec_table[i][67:52], vec_table[i][51:36],
				vec_table[i][32], vec_table[i][31:16], vec_table[i][15:0]);

		for (int i = 0; i < num_rand; i++) begin
			r = $random(seed);
			ra = r[15:0];
			r = $random(seed);
			rb = r[15:0];
			rop = r[16];
			// odd cases share the exponent so they cancel deeply
			if (i % 2 == 1)
				rb[14:10] = ra[14:10];
			ra[9] = 1'b1;
			rb[9] = 1'b1;
			compute_expected(ra, rb, rop, xres, xstat);
			run_case($sformatf("rand%0d", i), ra, rb, rop, xres, xstat);
		end

		// second control write arrives while busy
		start_case("busy_write", 16'h2A01, 16'h2A00, 1'b1);
		bus_write("busy_write ctrl2", fp_ctrl_pkg::addr_ctrl, 16'h0000);
		finish_case("busy_write", 16'h0600, 16'h0001);

		start_case("mid_reset", 16'h2A01, 16'h2A00, 1'b1);
		repeat (2) @(negedge got_fp);
		_0_f_ = 1'b0;
		repeat (2) @(negedge got_fp);
		_0_f_ = 1'b1;
		state_v = dut.u_seq.state;
		check_value("mid_reset state", idle_v, state_v);
		bus_read("mid_reset status", fp_ctrl_pkg::addr_ctrl, rd);
		check_value("mid_reset status", 16'h0000, rd);
		run_case("after_reset", 16'h1BFF, 16'h12FF, 1'b0, 16'h1E5F, 16'h0000);

		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb/fpu_asserts.sv
//////////////////////////////
// fpu assertions
// bus handshake and sequencer checks bound into the top level
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fpu_asserts (
	input logic got_fp,
	input logic _0_f_,
	input logic ack,
	input logic busy,
	input logic done,
	input logic ld_ops,
	input logic do_align,
	input logic do_add,
	input logic do_fix,
	input logic do_norm
);

	// ack lasts one cycle only
	ack_single: assert property (@(posedge got_fp) disable iff (!_0_f_)
		ack |=> !ack)
		else $error("ack high for two cycles in a row");

	// end of an operation is marked by done
	busy_end: assert property (@(posedge got_fp) disable iff (!_0_f_)
		$fell(busy) |-> $past(done))
		else $error("busy fell without a done pulse");

	enables_excl: assert property (@(posedge got_fp) disable iff (!_0_f_)
		$onehot0({ld_ops, do_align, do_add, do_fix, do_norm}))
		else $error("more than one datapath load enable high");

endmodule

bind fpu_top fpu_asserts u_asserts (
	.got_fp(got_fp), ._0_f_(_0_f_), .ack(ack), .busy(busy), .done(done),
	.ld_ops(ld_ops), .do_align(do_align), .do_add(do_add),
	.do_fix(do_fix), .do_norm(do_norm)
);

`default_nettype wire

//--- verilog/fpu_top.sv
//////////////////////////////
// fpu top
// add/subtract unit behind a wishbone slave
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fpu_top (
	input  logic got_fp,
	input  logic _0_f_,
	input  logic cyc,
	input  logic stb,
	input  logic we,
	input  fp_ctrl_pkg::adr_t adr,
	input  fp_format_pkg::fp_word_t dat_w,
	output fp_format_pkg::fp_word_t dat_r,
	output logic ack
);

	fp_format_pkg::fp_word_t op_a, op_b, res;
	logic op, start, busy, done, strobe;
	logic flag_zero, flag_ovf, flag_unf;
	logic step_go, step_long;
	logic ld_ops, do_align, do_add, do_fix, do_norm;
	logic norm_ok, carry, man_zero, exp_hit_max, exp_hit_min;

	fp_bus_slave u_slave (
		.got_fp(got_fp), ._0_f_(_0_f_),
		.cyc(cyc), .stb(stb), .we(we), .adr(adr),
		.dat_w(dat_w), .dat_r(dat_r), .ack(ack),
		.op_a(op_a), .op_b(op_b), .op(op), .start(start),
		.busy(busy), .done(done), .res(res),
		.flag_zero(flag_zero), .flag_ovf(flag_ovf), .flag_unf(flag_unf)
	);

	fp_sequencer u_seq (
		.got_fp(got_fp), ._0_f_(_0_f_), .start(start), .op(op),
		.strobe(strobe), .norm_ok(norm_ok), .carry(carry), .man_zero(man_zero),
		.exp_hit_max(exp_hit_max), .exp_hit_min(exp_hit_min),
		.step_go(step_go), .step_long(step_long),
		.ld_ops(ld_ops), .do_align(do_align), .do_add(do_add),
		.do_fix(do_fix), .do_norm(do_norm), .busy(busy), .done(done),
		.flag_zero(flag_zero), .flag_ovf(flag_ovf), .flag_unf(flag_unf)
	);

	fp_step_timer u_timer (
		.got_fp(got_fp), ._0_f_(_0_f_),
		.step_go(step_go), .step_long(step_long), .strobe(strobe)
	);

	// underflow flag flushes the result word
	fp_datapath u_dp (
		.got_fp(got_fp), ._0_f_(_0_f_),
		.op_a(op_a), .op_b(op_b), .op(op),
		.ld_ops(ld_ops), .do_align(do_align), .do_add(do_add),
		.do_fix(do_fix), .do_norm(do_norm), .flush(flag_unf),
		.res(res), .norm_ok(norm_ok), .carry(carry), .man_zero(man_zero),
		.exp_hit_max(exp_hit_max), .exp_hit_min(exp_hit_min)
	);

endmodule

`default_nettype wire

//--- verilog/fp_datapath.sv
//////////////////////////////
// datapath
// swap, align, add, carry fix and normalize registers
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fp_datapath (
	input  logic got_fp,
	input  logic _0_f_,
	input  fp_format_pkg::fp_word_t op_a,
	input  fp_format_pkg::fp_word_t op_b,
	input  logic op,
	input  logic ld_ops,
	input  logic do_align,
	input  logic do_add,
	input  logic do_fix,
	input  logic do_norm,
	input  logic flush,
	output fp_format_pkg::fp_word_t res,
	output logic norm_ok,
	output logic carry,
	output logic man_zero,
	output logic exp_hit_max,
	output logic exp_hit_min
);

	localparam int mag_w = fp_format_pkg::word_w - 1;
	localparam int man_w = fp_format_pkg::man_w;

	fp_format_pkg::fp_exp_t a_exp, b_exp, exp_r, shift_r;
	fp_format_pkg::fp_man_t a_man, b_man, man_l, man_s;
	fp_format_pkg::man_ext_t sum_r;
	logic [mag_w-1:0] key_a, key_b;
	logic a_sign, b_sign, swap, sign_r, eff_sub;

	assign a_sign = op_a[fp_format_pkg::sign_bit];
	assign b_sign = op_b[fp_format_pkg::sign_bit];
	assign a_exp = op_a[fp_format_pkg::exp_lsb +: fp_format_pkg::exp_w];
	assign b_exp = op_b[fp_format_pkg::exp_lsb +: fp_format_pkg::exp_w];
	assign a_man = op_a[man_w-1:0];
	assign b_man = op_b[man_w-1:0];

	// a zero mantissa ranks lowest whatever its exponent
	assign key_a = (a_man == '0) ? '0 : op_a[mag_w-1:0];
	assign key_b = (b_man == '0) ? '0 : op_b[mag_w-1:0];
	assign swap = key_b > key_a;

	always_ff @(posedge got_fp or negedge _0_f_) begin
		if (!_0_f_) begin
			sign_r <= 1'b0;
			eff_sub <= 1'b0;
			exp_r <= '0;
			shift_r <= '0;
			man_l <= '0;
			man_s <= '0;
			sum_r <= '0;
		end else if (ld_ops) begin
			sign_r <= swap ? (b_sign ^ op) : a_sign;
			eff_sub <= a_sign ^ b_sign ^ op;
			exp_r <= swap ? b_exp : a_exp;
			shift_r <= swap ? (b_exp - a_exp) : (a_exp - b_exp);
			man_l <= swap ? b_man : a_man;
			man_s <= swap ? a_man : b_man;
		end else if (do_align) begin
			// shifts of 11 and up leave nothing
			man_s <= man_s >> shift_r;
		end else if (do_add) begin
			if (eff_sub)
				sum_r <= {1'b0, man_l} - {1'b0, man_s};
			else
				sum_r <= {1'b0, man_l} + {1'b0, man_s};
		end else if (do_fix) begin
			if (carry) begin
				man_l <= sum_r[man_w:1];
				// exponent saturates, overflow is flagged
				if (!exp_hit_max)
					exp_r <= exp_r + 1'b1;
			end else begin
				man_l <= sum_r[man_w-1:0];
			end
		end else if (do_norm) begin
			man_l <= man_l << 1;
			exp_r <= exp_r - 1'b1;
		end
	end

	assign carry = sum_r[man_w];
	assign man_zero = man_l == '0;
	assign norm_ok = man_l[man_w-1] | man_zero;
	assign exp_hit_max = exp_r == fp_format_pkg::exp_max;
	assign exp_hit_min = exp_r == '0;

	// zero and underflow both give the all-zero word
	assign res = (flush || man_zero) ? '0 : {sign_r, exp_r, man_l};

endmodule

`default_nettype wire

//--- verilog/fp_sequencer.sv
//////////////////////////////
// sequencer
// steps the add/subtract phases and derives result flags
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fp_sequencer (
	input  logic got_fp,
	input  logic _0_f_,
	input  logic start,
	input  logic op,
	input  logic strobe,
	input  logic norm_ok,
	input  logic carry,
	input  logic man_zero,
	input  logic exp_hit_max,
	input  logic exp_hit_min,
	output logic step_go,
	output logic step_long,
	output logic ld_ops,
	output logic do_align,
	output logic do_add,
	output logic do_fix,
	output logic do_norm,
	output logic busy,
	output logic done,
	output logic flag_zero,
	output logic flag_ovf,
	output logic flag_unf
);

	fp_ctrl_pkg::seq_state_t state;
	logic norm_stop;

	// normalize ends on a leading one or at exponent zero
	assign norm_stop = norm_ok | exp_hit_min;

	always_ff @(posedge got_fp or negedge _0_f_) begin
		if (!_0_f_) begin
			state <= fp_ctrl_pkg::seq_idle;
			step_go <= 1'b0;
			flag_zero <= 1'b0;
			flag_ovf <= 1'b0;
			flag_unf <= 1'b0;
		end else begin
			step_go <= 1'b0;
			if (state == fp_ctrl_pkg::seq_idle) begin
				if (start) begin
					state <= fp_ctrl_pkg::seq_load;
					step_go <= 1'b1;
					flag_zero <= 1'b0;
					flag_ovf <= 1'b0;
					flag_unf <= 1'b0;
				end
			end else if (strobe) begin
				step_go <= 1'b1;
				unique case (state)
					fp_ctrl_pkg::seq_load: state <= fp_ctrl_pkg::seq_align;
					fp_ctrl_pkg::seq_align: state <= fp_ctrl_pkg::seq_add;
					fp_ctrl_pkg::seq_add: state <= fp_ctrl_pkg::seq_fix;
					fp_ctrl_pkg::seq_fix: begin
						state <= fp_ctrl_pkg::seq_norm;
						if (carry && exp_hit_max)
							flag_ovf <= 1'b1;
					end
					fp_ctrl_pkg::seq_norm: begin
						// stays here one shift per strobe
						if (norm_ok) begin
							state <= fp_ctrl_pkg::seq_done;
							flag_zero <= man_zero;
						end else if (exp_hit_min) begin
							state <= fp_ctrl_pkg::seq_done;
							flag_unf <= 1'b1;
						end
					end
					default: begin
						state <= fp_ctrl_pkg::seq_idle;
						step_go <= 1'b0;
					end
				endcase
			end
		end
	end

	// align shift and adder settle longer
	assign step_long = state == fp_ctrl_pkg::seq_align ||
		state == fp_ctrl_pkg::seq_add;

	assign busy = state != fp_ctrl_pkg::seq_idle;

	assign ld_ops = strobe && state == fp_ctrl_pkg::seq_load;
	assign do_align = strobe && state == fp_ctrl_pkg::seq_align;
	assign do_add = strobe && state == fp_ctrl_pkg::seq_add;
	assign do_fix = strobe && state == fp_ctrl_pkg::seq_fix;
	assign do_norm = strobe && state == fp_ctrl_pkg::seq_norm && !norm_stop;
	assign done = strobe && state == fp_ctrl_pkg::seq_done;

endmodule

`default_nettype wire

//--- verilog/fp_bus_slave.sv
//////////////////////////////
// bus slave
// wishbone classic registers for operands, control and result
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fp_bus_slave (
	input  logic got_fp,
	input  logic _0_f_,
	input  logic cyc,
	input  logic stb,
	input  logic we,
	input  fp_ctrl_pkg::adr_t adr,
	input  fp_format_pkg::fp_word_t dat_w,
	output fp_format_pkg::fp_word_t dat_r,
	output logic ack,
	output fp_format_pkg::fp_word_t op_a,
	output fp_format_pkg::fp_word_t op_b,
	output logic op,
	output logic start,
	input  logic busy,
	input  logic done,
	input  fp_format_pkg::fp_word_t res,
	input  logic flag_zero,
	input  logic flag_ovf,
	input  logic flag_unf
);

	fp_format_pkg::fp_word_t res_q;
	fp_format_pkg::fp_word_t rd_data;
	logic zero_q, ovf_q, unf_q;
	logic req, wr_en;

	// new request, ack not yet given
	assign req = cyc & stb & ~ack;
	assign wr_en = req & we;

	always_ff @(posedge got_fp or negedge _0_f_) begin
		if (!_0_f_) begin
			ack <= 1'b0;
			start <= 1'b0;
			op <= 1'b0;
			zero_q <= 1'b0;
			ovf_q <= 1'b0;
			unf_q <= 1'b0;
		end else begin
			ack <= req;
			start <= 1'b0;
			// control write while busy is acked and dropped
			if (wr_en && adr == fp_ctrl_pkg::addr_ctrl && !busy) begin
				start <= 1'b1;
				op <= dat_w[fp_ctrl_pkg::ctrl_op_bit];
			end
			if (done) begin
				zero_q <= flag_zero;
				ovf_q <= flag_ovf;
				unf_q <= flag_unf;
			end
		end
	end

	always_ff @(posedge got_fp) begin
		if (wr_en && adr == fp_ctrl_pkg::addr_a)
			op_a <= dat_w;
		if (wr_en && adr == fp_ctrl_pkg::addr_b)
			op_b <= dat_w;
		if (done)
			res_q <= res;
		if (req)
			dat_r <= rd_data;
	end

	always_comb begin
		rd_data = '0;
		case (adr)
			fp_ctrl_pkg::addr_a: rd_data = op_a;
			fp_ctrl_pkg::addr_b: rd_data = op_b;
			fp_ctrl_pkg::addr_ctrl: begin
				// status word
				rd_data[fp_ctrl_pkg::ctrl_op_bit] = op;
				rd_data[fp_ctrl_pkg::stat_zero] = zero_q;
				rd_data[fp_ctrl_pkg::stat_ovf] = ovf_q;
				rd_data[fp_ctrl_pkg::stat_unf] = unf_q;
				rd_data[fp_ctrl_pkg::stat_busy] = busy;
			end
			default: rd_data = res_q;
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/fp_step_timer.sv
//////////////////////////////
// step timer
// counter one-shot giving each step its settle time
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fp_step_timer (
	input  logic got_fp,
	input  logic _0_f_,
	input  logic step_go,
	input  logic step_long,
	output logic strobe
);

	fp_ctrl_pkg::settle_t cnt;
	logic run;

	always_ff @(posedge got_fp or negedge _0_f_) begin
		if (!_0_f_) begin
			cnt <= '0;
			run <= 1'b0;
			strobe <= 1'b0;
		end else begin
			strobe <= 1'b0;
			if (step_go) begin
				// retrigger, a new step restarts the count
				cnt <= step_long ? fp_ctrl_pkg::settle_long : fp_ctrl_pkg::settle_short;
				run <= 1'b1;
			end else if (run) begin
				if (cnt == '0) begin
					run <= 1'b0;
					strobe <= 1'b1;
				end else begin
					cnt <= cnt - 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/fp_ctrl_pkg.sv
//////////////////////////////
// fp control
// sequencer states, register map and step timing
//////////////////////////////

`default_nettype none

package fp_ctrl_pkg;

	typedef enum logic [2:0] {
		seq_idle,
		seq_load,
		seq_align,
		seq_add,
		seq_fix,
		seq_norm,
		seq_done
	} seq_state_t;

	localparam int adr_w = 2;
	typedef logic [adr_w-1:0] adr_t;

	localparam adr_t addr_a = 2'd0;
	localparam adr_t addr_b = 2'd1;
	localparam adr_t addr_ctrl = 2'd2;
	localparam adr_t addr_res = 2'd3;

	// control word, op shares its bit with the status readback
	localparam int ctrl_op_bit = 0;
	localparam int stat_zero = 1;
	localparam int stat_ovf = 2;
	localparam int stat_unf = 3;
	localparam int stat_busy = 15;

	localparam int settle_w = 3;
	typedef logic [settle_w-1:0] settle_t;

	localparam settle_t settle_short = 3'd1;
	localparam settle_t settle_long = 3'd3;

endpackage

`default_nettype wire

//--- verilog/fp_format_pkg.sv
//////////////////////////////
// fp format
// widths and field types of the 16-bit add/subtract word
//////////////////////////////

`default_nettype none

package fp_format_pkg;

	localparam int word_w = 16;
	localparam int exp_w = 5;
	localparam int man_w = 10;

	// sign, unbiased exponent, mantissa with explicit leading one
	typedef logic [word_w-1:0] fp_word_t;
	typedef logic [exp_w-1:0] fp_exp_t;
	typedef logic [man_w-1:0] fp_man_t;

	// mantissa plus carry position out of the adder
	typedef logic [man_w:0] man_ext_t;

	localparam fp_exp_t exp_max = 5'd31;

	// field positions inside a word
	localparam int sign_bit = word_w - 1;
	localparam int exp_lsb = man_w;

endpackage

`default_nettype wire
